// ==== Makefile ====
# Verilator build and run for the hardware-loop unit testbench
# override any variable on the command line, e.g. make run LOG=run1.log

VERILATOR ?= verilator
TOP       ?= hwlp_tb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Regression passed
VFLAGS    ?= --binary --timing --assert

SRCS := $(filter-out +%,$(shell cat $(FILELIST)))
HDRS := $(wildcard sim/*.svh)
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# rebuilt only when a source, header or the file list changes
$(BIN): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# the log decides pass or fail
run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== hdl/hwlp_ctrl.sv ====
// hardware-loop controller
//   qualifies matcher hits with the retire strobe
//   priority encoder, lowest index (innermost loop) wins
//   one-hot decrement, jump request and jump target for fetch

`timescale 1ns/1ps

module hwlp_ctrl
#(
  parameter int unsigned N_LOOPS = 2,
  localparam int unsigned IDX_W = (N_LOOPS > 1) ? $clog2(N_LOOPS) : 1
)
(
  // only used by the checks below
  input  logic                                          clk,
  input  logic                                          rst_n,

  // retire strobe
  input  logic                                          valid_i,

  // matcher results and start addresses
  input  hwlp_pkg::hwlp_hit_t [N_LOOPS-1:0]             hits_i,
  input  logic [N_LOOPS-1:0][hwlp_pkg::HWLP_XLEN-1:0]   start_addr_i,

  // to fetch
  output logic                                          jump_o,
  output logic [hwlp_pkg::HWLP_XLEN-1:0]                jump_target_o,

  // back to the register file
  output logic [N_LOOPS-1:0]                            dec_cnt_o
);

  import hwlp_pkg::*;

  // loops whose end is retiring this cycle with a nonzero count
  logic [N_LOOPS-1:0] hit_vec;
  logic               found;
  logic [IDX_W-1:0]   win_idx;
  hwlp_hit_t          win_hit;

  ////////////////////////////////////////
  // hit qualification
  ////////////////////////////////////////

  always_comb
  begin
    for (int i = 0; i < N_LOOPS; i++)
      hit_vec[i] = valid_i && hits_i[i].at_end && hits_i[i].live;
  end

  ////////////////////////////////////////
  // priority select
  ////////////////////////////////////////

  // scan from the top down so the lowest hitting index is the last one written
  always_comb
  begin
    found   = 1'b0;
    win_idx = '0;
    for (int i = N_LOOPS - 1; i >= 0; i--)
    begin
      if (hit_vec[i])
      begin
        found   = 1'b1;
        win_idx = IDX_W'(i);
      end
    end
  end

  assign win_hit = hits_i[win_idx];

  ////////////////////////////////////////
  // outputs
  ////////////////////////////////////////

  // winner always counts down, even on its last pass
  always_comb
  begin
    dec_cnt_o = '0;
    if (found)
      dec_cnt_o[win_idx] = 1'b1;
  end

  // jump back only if another pass follows, count==1 falls through
  assign jump_o        = found && win_hit.again;
  // follows win_idx even without a jump, fetch ignores it then
  assign jump_target_o = start_addr_i[win_idx];

  // single winner
  assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0(dec_cnt_o));

  // no jump without counting the pass
  assert property (@(posedge clk) disable iff (!rst_n)
    jump_o |-> (dec_cnt_o != '0));

endmodule

// ==== hdl/hwlp_match.sv ====
// end-address matcher
//   compares the retiring pc against every loop end address
//   classifies each counter as zero, one or above one
//   packs the result into one hwlp_hit_t per loop

`timescale 1ns/1ps

module hwlp_match
#(
  parameter int unsigned N_LOOPS = 2
)
(
  // retiring pc, not qualified here
  input  logic [hwlp_pkg::HWLP_XLEN-1:0]                pc_i,

  // registered loop state
  input  logic [N_LOOPS-1:0][hwlp_pkg::HWLP_XLEN-1:0]   end_addr_i,
  input  logic [N_LOOPS-1:0][hwlp_pkg::HWLP_XLEN-1:0]   counter_i,

  // per-loop status to the controller
  output hwlp_pkg::hwlp_hit_t [N_LOOPS-1:0]             hits_o
);

  import hwlp_pkg::*;

  // raw per-loop flags before packing
  logic [N_LOOPS-1:0] pc_eq;
  logic [N_LOOPS-1:0] cnt_nz;
  logic [N_LOOPS-1:0] cnt_gt1;

  ////////////////////////////////////////
  // per-loop compare
  ////////////////////////////////////////

  for (genvar g = 0; g < N_LOOPS; g++)
  begin : g_loop
    // upper counter bits, anything set here means count >= 2
    logic [HWLP_XLEN-1:1] cnt_hi;

    assign cnt_hi = counter_i[g][HWLP_XLEN-1:1];

    // full-width equality, no alignment assumptions on the end address
    assign pc_eq[g] = (pc_i == end_addr_i[g]);

    // zero / one / more than one
    // nonzero: any bit set
    assign cnt_nz[g]  = |counter_i[g];
    // above one: any bit other than the lsb set
    assign cnt_gt1[g] = |cnt_hi;
  end

  ////////////////////////////////////////
  // pack
  ////////////////////////////////////////

  // valid_i qualification happens in the controller
  always_comb
  begin
    for (int i = 0; i < N_LOOPS; i++)
    begin
      hits_o[i].at_end = pc_eq[i];
      hits_o[i].live   = cnt_nz[i];
      hits_o[i].again  = cnt_gt1[i];
    end
  end

endmodule

// ==== hdl/hwlp_pkg.sv ====
// shared definitions for the hardware-loop unit
//   HWLP_XLEN   address and counter width
//   hwlp_we_t   setup write strobes from the execute stage
//   hwlp_csr_e  csr read selector
//   hwlp_hit_t  per-loop status as seen by the end-address matcher

package hwlp_pkg;

  ////////////////////////////////////////
  // widths
  ////////////////////////////////////////

  // pc, start/end addresses and iteration counters all share this width
  parameter int unsigned HWLP_XLEN = 32;

  ////////////////////////////////////////
  // setup write strobes
  ////////////////////////////////////////

  // one strobe per register kind, all aimed at the same loop index
  // bit order matches the ex stage encoding: [2] count, [1] end, [0] start
  typedef struct packed {
    // load the iteration counter
    logic cnt_we;
    // load the end address (address of the last body instruction)
    logic end_we;
    // load the start address (jump target)
    logic start_we;
  } hwlp_we_t;

  ////////////////////////////////////////
  // csr read selector
  ////////////////////////////////////////

  // picks which of the three loop registers the csr port returns
  // the fourth code is unused and reads as zero
  typedef enum logic [1:0] {
    HWLP_CSR_START = 2'd0,
    HWLP_CSR_END   = 2'd1,
    HWLP_CSR_COUNT = 2'd2
  } hwlp_csr_e;

  ////////////////////////////////////////
  // per-loop match result
  ////////////////////////////////////////

  // produced by the matcher for every loop each cycle
  // the controller only looks at loops where at_end and live are both set
  typedef struct packed {
    // retiring pc sits on this loop's end address
    logic at_end;
    // counter is nonzero, so the loop is still running
    logic live;
    // counter above one, so another pass follows and fetch must jump
    logic again;
  } hwlp_hit_t;

endpackage

// ==== hdl/hwlp_regs.sv ====
// hardware-loop register file
//   start, end and counter arrays with asynchronous reset
//   indexed setup writes from the execute stage
//   counter decrement on a taken loop end unless a count write wins
//   csr readback multiplexer

`timescale 1ns/1ps

module hwlp_regs
#(
  parameter int unsigned N_LOOPS = 2,
  localparam int unsigned IDX_W = (N_LOOPS > 1) ? $clog2(N_LOOPS) : 1
)
(
  input  logic                                          clk,
  input  logic                                          rst_n,

  // setup writes from ex stage
  input  hwlp_pkg::hwlp_we_t                            we_i,
  input  logic [IDX_W-1:0]                              regid_i,
  input  logic [hwlp_pkg::HWLP_XLEN-1:0]                start_data_i,
  input  logic [hwlp_pkg::HWLP_XLEN-1:0]                end_data_i,
  input  logic [hwlp_pkg::HWLP_XLEN-1:0]                cnt_data_i,

  // retire strobe and one-hot decrement from the controller
  input  logic                                          valid_i,
  input  logic [N_LOOPS-1:0]                            dec_cnt_i,

  // csr read port
  input  logic [IDX_W-1:0]                              csr_regid_i,
  input  hwlp_pkg::hwlp_csr_e                           csr_sel_i,

  // registered values to matcher and controller
  output logic [N_LOOPS-1:0][hwlp_pkg::HWLP_XLEN-1:0]   start_addr_o,
  output logic [N_LOOPS-1:0][hwlp_pkg::HWLP_XLEN-1:0]   end_addr_o,
  output logic [N_LOOPS-1:0][hwlp_pkg::HWLP_XLEN-1:0]   counter_o,
  output logic [hwlp_pkg::HWLP_XLEN-1:0]                csr_rdata_o
);

  import hwlp_pkg::*;

  logic [N_LOOPS-1:0][HWLP_XLEN-1:0] start_q;
  logic [N_LOOPS-1:0][HWLP_XLEN-1:0] end_q;
  logic [N_LOOPS-1:0][HWLP_XLEN-1:0] counter_q;

  // per-loop counter update requests
  logic [N_LOOPS-1:0]                cnt_wr;
  logic [N_LOOPS-1:0]                cnt_dec;

  assign start_addr_o = start_q;
  assign end_addr_o   = end_q;
  assign counter_o    = counter_q;

  ////////////////////////////////////////
  // address registers
  ////////////////////////////////////////

  // start and end load independently at the shared loop index
  always_ff @(posedge clk, negedge rst_n)
  begin : addr_regs
    if (!rst_n)
    begin
      start_q <= '0;
      end_q   <= '0;
    end
    else
    begin
      for (int i = 0; i < N_LOOPS; i++)
      begin
        if (we_i.start_we && (regid_i == IDX_W'(i)))
          start_q[i] <= start_data_i;
        if (we_i.end_we && (regid_i == IDX_W'(i)))
          end_q[i] <= end_data_i;
      end
    end
  end

  ////////////////////////////////////////
  // counter registers
  ////////////////////////////////////////

  // a count write to the same loop masks the decrement
  always_comb
  begin
    for (int i = 0; i < N_LOOPS; i++)
    begin
      cnt_wr[i]  = we_i.cnt_we && (regid_i == IDX_W'(i));
      cnt_dec[i] = valid_i && dec_cnt_i[i] && !cnt_wr[i];
    end
  end

  always_ff @(posedge clk, negedge rst_n)
  begin : cnt_regs
    if (!rst_n)
    begin
      counter_q <= '0;
    end
    else
    begin
      for (int i = 0; i < N_LOOPS; i++)
      begin
        if (cnt_wr[i])
          counter_q[i] <= cnt_data_i;
        else if (cnt_dec[i])
          counter_q[i] <= counter_q[i] - HWLP_XLEN'(1);
      end
    end
  end

  ////////////////////////////////////////
  // csr readback
  ////////////////////////////////////////

  // out-of-range index or unused selector code reads as zero
  always_comb
  begin
    csr_rdata_o = '0;
    for (int i = 0; i < N_LOOPS; i++)
    begin
      if (csr_regid_i == IDX_W'(i))
      begin
        case (csr_sel_i)
          HWLP_CSR_START: csr_rdata_o = start_q[i];
          HWLP_CSR_END:   csr_rdata_o = end_q[i];
          HWLP_CSR_COUNT: csr_rdata_o = counter_q[i];
          default:        csr_rdata_o = '0;
        endcase
      end
    end
  end

  // controller picks a single winner and never requests two decrements
  assert property (@(posedge clk) disable iff (!rst_n)
    valid_i |-> $onehot0(dec_cnt_i));

  // a decrement only ever targets a nonzero counter and never wraps
  for (genvar g = 0; g < N_LOOPS; g++)
  begin : g_nowrap
    assert property (@(posedge clk) disable iff (!rst_n)
      (valid_i && dec_cnt_i[g]) |-> (counter_q[g] != '0));
  end

endmodule

// ==== hdl/hwlp_unit.sv ====
// hardware-loop unit top level
//   hwlp_regs   loop registers, setup writes, decrement, csr read
//   hwlp_match  pc vs end-address compare per loop
//   hwlp_ctrl   winner select, jump and decrement

`timescale 1ns/1ps

module hwlp_unit
#(
  parameter int unsigned N_LOOPS = 2,
  localparam int unsigned IDX_W = (N_LOOPS > 1) ? $clog2(N_LOOPS) : 1
)
(
  input  logic                             clk,
  input  logic                             rst_n,

  // retire side
  input  logic                             valid_i,
  input  logic [hwlp_pkg::HWLP_XLEN-1:0]   pc_i,

  // setup writes from ex stage
  input  hwlp_pkg::hwlp_we_t               we_i,
  input  logic [IDX_W-1:0]                 regid_i,
  input  logic [hwlp_pkg::HWLP_XLEN-1:0]   start_data_i,
  input  logic [hwlp_pkg::HWLP_XLEN-1:0]   end_data_i,
  input  logic [hwlp_pkg::HWLP_XLEN-1:0]   cnt_data_i,

  // csr read port
  input  logic [IDX_W-1:0]                 csr_regid_i,
  input  hwlp_pkg::hwlp_csr_e              csr_sel_i,
  output logic [hwlp_pkg::HWLP_XLEN-1:0]   csr_rdata_o,

  // to fetch
  output logic                             jump_o,
  output logic [hwlp_pkg::HWLP_XLEN-1:0]   jump_target_o
);

  import hwlp_pkg::*;

  logic [N_LOOPS-1:0][HWLP_XLEN-1:0] start_addr;
  logic [N_LOOPS-1:0][HWLP_XLEN-1:0] end_addr;
  logic [N_LOOPS-1:0][HWLP_XLEN-1:0] counter;
  hwlp_hit_t [N_LOOPS-1:0]           hits;
  logic [N_LOOPS-1:0]                dec_cnt;

  ////////////////////////////////////////
  // registers
  ////////////////////////////////////////

  hwlp_regs #(
    .N_LOOPS      (N_LOOPS)
  ) u_regs (
    .clk          (clk),
    .rst_n        (rst_n),
    .we_i         (we_i),
    .regid_i      (regid_i),
    .start_data_i (start_data_i),
    .end_data_i   (end_data_i),
    .cnt_data_i   (cnt_data_i),
    .valid_i      (valid_i),
    .dec_cnt_i    (dec_cnt),
    .csr_regid_i  (csr_regid_i),
    .csr_sel_i    (csr_sel_i),
    .start_addr_o (start_addr),
    .end_addr_o   (end_addr),
    .counter_o    (counter),
    .csr_rdata_o  (csr_rdata_o)
  );

  ////////////////////////////////////////
  // matcher and controller
  ////////////////////////////////////////

  hwlp_match #(
    .N_LOOPS      (N_LOOPS)
  ) u_match (
    .pc_i         (pc_i),
    .end_addr_i   (end_addr),
    .counter_i    (counter),
    .hits_o       (hits)
  );

  // closes the loop back into u_regs through dec_cnt
  hwlp_ctrl #(
    .N_LOOPS       (N_LOOPS)
  ) u_ctrl (
    .clk           (clk),
    .rst_n         (rst_n),
    .valid_i       (valid_i),
    .hits_i        (hits),
    .start_addr_i  (start_addr),
    .jump_o        (jump_o),
    .jump_target_o (jump_target_o),
    .dec_cnt_o     (dec_cnt)
  );

endmodule

// ==== sim/hwlp_model.svh ====
// reference model of the hardware-loop unit
//   one cycle of testbench inputs as a packed struct
//   loop register arrays kept apart from the DUT
//   innermost-hit rule, jump, target and csr prediction
//   next-state update, a count write overrides the decrement

`ifndef HWLP_MODEL_SVH
`define HWLP_MODEL_SVH

// everything the testbench drives in one cycle
typedef struct packed {
  logic                 valid;
  logic [HWLP_XLEN-1:0] pc;
  hwlp_we_t             we;
  logic [IDX_W-1:0]     regid;
  logic [HWLP_XLEN-1:0] sd;
  logic [HWLP_XLEN-1:0] ed;
  logic [HWLP_XLEN-1:0] cd;
  logic [IDX_W-1:0]     cregid;
  logic [1:0]           csel;
} stim_t;

logic [HWLP_XLEN-1:0] m_start [N_LOOPS];
logic [HWLP_XLEN-1:0] m_end   [N_LOOPS];
logic [HWLP_XLEN-1:0] m_cnt   [N_LOOPS];

function automatic void reset_model();
  for (int i = 0; i < N_LOOPS; i++)
  begin
    m_start[i] = '0;
    m_end[i]   = '0;
    m_cnt[i]   = '0;
  end
endfunction

// first loop, counting up from 0, whose end retires with a nonzero count
// -1 when no loop hits
function automatic int find_winner(input stim_t s);
  int w;
  w = -1;
  for (int i = 0; i < N_LOOPS; i++)
  begin
    if (w < 0 && s.valid && (s.pc == m_end[i]) && (m_cnt[i] != '0))
      w = i;
  end
  return w;
endfunction

// jump only while another pass follows
function automatic logic predict_jump(input stim_t s);
  int w;
  w = find_winner(s);
  if (w < 0)
    return 1'b0;
  return m_cnt[w] > 1;
endfunction

function automatic logic [HWLP_XLEN-1:0] predict_target(input stim_t s);
  int w;
  w = find_winner(s);
  if (w < 0)
    return '0;
  return m_start[w];
endfunction

// unused selector code and out-of-range index read as zero
function automatic logic [HWLP_XLEN-1:0] predict_csr(input stim_t s);
  int r;
  r = int'(s.cregid);
  if (r >= N_LOOPS)
    return '0;
  case (hwlp_csr_e'(s.csel))
    HWLP_CSR_START: return m_start[r];
    HWLP_CSR_END:   return m_end[r];
    HWLP_CSR_COUNT: return m_cnt[r];
    default:        return '0;
  endcase
endfunction

// state after the next rising edge
function automatic void advance_model(input stim_t s);
  int w;
  int r;
  w = find_winner(s);
  r = int'(s.regid);
  if (w >= 0)
    m_cnt[w] = m_cnt[w] - 1;
  // writes land last so a count write wins over the decrement
  if (r < N_LOOPS)
  begin
    if (s.we.start_we)
      m_start[r] = s.sd;
    if (s.we.end_we)
      m_end[r] = s.ed;
    if (s.we.cnt_we)
      m_cnt[r] = s.cd;
  end
endfunction

`endif

// ==== sim/hwlp_tb.sv ====
// testbench for the hardware-loop unit
//   clock, reset and registered input driving
//   reset, csr readback, loop walks, priority and override phases
//   long mixed random phase from a fixed seed
//   per-cycle compare against the model, timeout and summary

`timescale 1ns/1ps

module hwlp_tb;

  import hwlp_pkg::*;

  localparam int unsigned N_LOOPS = 2;
  localparam int unsigned IDX_W   = (N_LOOPS > 1) ? $clog2(N_LOOPS) : 1;
  localparam int STIM_CYCLES      = 2000;
  localparam int TIMEOUT_CYCLES   = STIM_CYCLES * 3 / 2;

  `include "hwlp_model.svh"

  logic                 clk = 1'b0;
  logic                 rst_n;
  logic                 valid_i;
  logic [HWLP_XLEN-1:0] pc_i;
  hwlp_we_t             we_i;
  logic [IDX_W-1:0]     regid_i;
  logic [HWLP_XLEN-1:0] start_data_i;
  logic [HWLP_XLEN-1:0] end_data_i;
  logic [HWLP_XLEN-1:0] cnt_data_i;
  logic [IDX_W-1:0]     csr_regid_i;
  hwlp_csr_e            csr_sel_i;
  logic [HWLP_XLEN-1:0] csr_rdata_o;
  logic                 jump_o;
  logic [HWLP_XLEN-1:0] jump_target_o;

  integer seed = 90;
  int errors = 0;
  int checks = 0;
  int cycle_cnt = 0;
  // latest model prediction, also steers the pc walks
  logic                 exp_jump;
  logic [HWLP_XLEN-1:0] exp_tgt;

  hwlp_unit #(
    .N_LOOPS       (N_LOOPS)
  ) uut (
    .clk           (clk),
    .rst_n         (rst_n),
    .valid_i       (valid_i),
    .pc_i          (pc_i),
    .we_i          (we_i),
    .regid_i       (regid_i),
    .start_data_i  (start_data_i),
    .end_data_i    (end_data_i),
    .cnt_data_i    (cnt_data_i),
    .csr_regid_i   (csr_regid_i),
    .csr_sel_i     (csr_sel_i),
    .csr_rdata_o   (csr_rdata_o),
    .jump_o        (jump_o),
    .jump_target_o (jump_target_o)
  );

  ////////////////////////////////////////
  // clock and watchdog
  ////////////////////////////////////////

  always #20 clk = ~clk;

  always @(posedge clk)
    cycle_cnt <= cycle_cnt + 1;

  initial
  begin
    wait (cycle_cnt >= TIMEOUT_CYCLES);
    errors++;
    $display("timeout: run still going after %0d cycles", TIMEOUT_CYCLES);
    $display("Regression failed");
    $finish;
  end

  ////////////////////////////////////////
  // stimulus helpers
  ////////////////////////////////////////

  function automatic logic [HWLP_XLEN-1:0] rand_word();
    return $random(seed);
  endfunction

  function automatic stim_t with_rand_csr(input stim_t s);
    logic [HWLP_XLEN-1:0] r;
    r = rand_word();
    s.cregid = r[IDX_W-1:0];
    // all four codes, the spare one included
    s.csel = r[9:8];
    return s;
  endfunction

  // drive one cycle, then compare once the combinational paths settle
  task automatic apply_cycle(input stim_t s);
    logic [HWLP_XLEN-1:0] exp_csr;
    @(posedge clk);
    valid_i      <= s.valid;
    pc_i         <= s.pc;
    we_i         <= s.we;
    regid_i      <= s.regid;
    start_data_i <= s.sd;
    end_data_i   <= s.ed;
    cnt_data_i   <= s.cd;
    csr_regid_i  <= s.cregid;
    csr_sel_i    <= hwlp_csr_e'(s.csel);
    #10;
    exp_jump = predict_jump(s);
    exp_tgt  = predict_target(s);
    exp_csr  = predict_csr(s);
    checks++;
    if (jump_o !== exp_jump)
    begin
      errors++;
      $display("FAILED jump_o expected %h got %h at %0t", exp_jump, jump_o, $time);
    end
    // target is only defined while a jump is requested
    if (exp_jump && (jump_target_o !== exp_tgt))
    begin
      errors++;
      $display("FAILED jump_target_o expected %h got %h at %0t", exp_tgt, jump_target_o,
               $time);
    end
    if (csr_rdata_o !== exp_csr)
    begin
      errors++;
      $display("FAILED csr_rdata_o expected %h got %h at %0t", exp_csr, csr_rdata_o, $time);
    end
    advance_model(s);
  endtask

  task automatic write_loop(input int idx, input logic [HWLP_XLEN-1:0] first,
                            input logic [HWLP_XLEN-1:0] last, input logic [HWLP_XLEN-1:0] cnt);
    stim_t s;
    s = '0;
    s.we = hwlp_we_t'(3'b111);
    s.regid = IDX_W'(idx);
    s.sd = first;
    s.ed = last;
    s.cd = cnt;
    apply_cycle(s);
  endtask

  // retire the body from first to last, following predicted jumps
  // while reading back the loop counter
  task automatic walk_loop(input int idx, input logic [HWLP_XLEN-1:0] first,
                           input logic [HWLP_XLEN-1:0] last);
    stim_t s;
    logic [HWLP_XLEN-1:0] pc;
    pc = first;
    for (int n = 0; n < 64 && pc <= last; n++)
    begin
      s = '0;
      s.valid = 1'b1;
      s.pc = pc;
      s.cregid = IDX_W'(idx);
      s.csel = HWLP_CSR_COUNT;
      apply_cycle(s);
      pc = exp_jump ? exp_tgt : pc + 4;
    end
  endtask

  ////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////

  initial
  begin
    stim_t s;
    logic [HWLP_XLEN-1:0] r;
    logic [HWLP_XLEN-1:0] r2;
    rst_n        <= 1'b0;
    valid_i      <= 1'b0;
    pc_i         <= '0;
    we_i         <= '0;
    regid_i      <= '0;
    start_data_i <= '0;
    end_data_i   <= '0;
    cnt_data_i   <= '0;
    csr_regid_i  <= '0;
    csr_sel_i    <= HWLP_CSR_START;
    reset_model();
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;

    // after reset every register reads zero, no pc jumps
    for (int n = 0; n < 24; n++)
    begin
      s = '0;
      s.valid = 1'b1;
      s.pc = rand_word();
      apply_cycle(with_rand_csr(s));
    end

    // random setup writes read back through the csr port
    for (int n = 0; n < 300; n++)
    begin
      r = rand_word();
      s = '0;
      s.we = hwlp_we_t'(r[2:0]);
      s.regid = r[3 +: IDX_W];
      s.sd = rand_word();
      s.ed = rand_word();
      s.cd = rand_word();
      apply_cycle(with_rand_csr(s));
    end

    // plain loops, walked to exhaustion and once more while inert
    write_loop(0, 32'h0000_0100, 32'h0000_010c, 32'd3);
    write_loop(1, 32'h0000_0200, 32'h0000_0214, 32'd2);
    walk_loop(0, 32'h0000_0100, 32'h0000_010c);
    walk_loop(0, 32'h0000_0100, 32'h0000_010c);
    walk_loop(1, 32'h0000_0200, 32'h0000_0214);
    walk_loop(1, 32'h0000_0200, 32'h0000_0214);

    // shared end address, loop 0 drains first, then loop 1 takes over
    write_loop(0, 32'h0000_02f0, 32'h0000_0300, 32'd3);
    write_loop(1, 32'h0000_02e0, 32'h0000_0300, 32'd5);
    for (int n = 0; n < 6; n++)
    begin
      s = '0;
      s.valid = 1'b1;
      s.pc = 32'h0000_0300;
      s.cregid = IDX_W'(n % 2);
      s.csel = HWLP_CSR_COUNT;
      apply_cycle(s);
    end

    // count write during a hit, then an end address with valid low
    write_loop(0, 32'h0000_03f0, 32'h0000_0400, 32'd4);
    s = '0;
    s.valid = 1'b1;
    s.pc = 32'h0000_0400;
    s.we = hwlp_we_t'(3'b100);
    s.cd = 32'd9;
    s.csel = HWLP_CSR_COUNT;
    apply_cycle(s);
    s.valid = 1'b0;
    s.we = '0;
    apply_cycle(s);
    apply_cycle(s);

    // mixed random traffic around the current end addresses
    for (int n = 0; n < 1500; n++)
    begin
      r = rand_word();
      r2 = rand_word();
      s = '0;
      s.valid = (r[1:0] != 2'b00);
      s.pc = m_end[int'(r[5 +: IDX_W])];
      case (r[4:2])
        3'd0: s.pc = {20'd0, r2[11:2], 2'b00};
        3'd1: s.pc = s.pc - 4;
        3'd2: s.pc = s.pc + 4;
        default: s.pc = s.pc;
      endcase
      // occasional setup write with small addresses and counts
      if (r[10:8] == 3'd0)
      begin
        s.we = hwlp_we_t'(r2[14:12]);
        s.regid = r2[16 +: IDX_W];
        s.sd = {20'd0, r2[27:18], 2'b00};
        s.ed = {20'd0, r[21:12], 2'b00};
        s.cd = HWLP_XLEN'(r2[30:28]);
      end
      apply_cycle(with_rand_csr(s));
    end

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0)
      $display("Regression passed");
    else
      $display("Regression failed");
    $finish;
  end

endmodule

// ==== sources.f ====
+incdir+sim
hdl/hwlp_pkg.sv
hdl/hwlp_regs.sv
hdl/hwlp_match.sv
hdl/hwlp_ctrl.sv
hdl/hwlp_unit.sv
sim/hwlp_tb.sv
